// File: Makefile
VERILATOR  ?= verilator
TOP        := ldq_tb
FLIST      := flist.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: flist.f
src/ldq_pkg.sv
src/ldq_upd_select.sv
src/ldq_entry.sv
src/ldq_alloc.sv
src/ldq_haz_check.sv
src/ldq_top.sv
test/ldq_tb.sv

// File: src/ldq_alloc.sv
// Load queue allocator
`timescale 1ns/10ps

module ldq_alloc #(
  parameter int LDQ_SIZE = 8,
  parameter int DISP_W   = 2
) (
  input  logic                            i_clk,
  input  logic                            i_reset_n,
  input  ldq_pkg::ldq_disp_t              i_disp [DISP_W],
  input  ldq_pkg::ldq_commit_t            i_commit,
  input  logic [LDQ_SIZE-1:0]             i_entry_valids,
  input  logic [LDQ_SIZE-1:0]             i_retire,
  output logic [LDQ_SIZE-1:0]             o_alloc,
  output ldq_pkg::cmt_id_t                o_alloc_cmt_id [LDQ_SIZE],
  output logic [LDQ_SIZE-1:0]             o_in_ptr_oh,
  output logic [LDQ_SIZE-1:0]             o_out_ptr_oh,
  output logic                            o_credit_valid,
  output logic [$clog2(LDQ_SIZE+1)-1:0]   o_credit_cnt
);
  import ldq_pkg::*;

  localparam int PTR_W = (LDQ_SIZE > 1) ? $clog2(LDQ_SIZE) : 1;
  localparam int CNT_W = $clog2(LDQ_SIZE+1);

  logic [PTR_W-1:0] r_in_ptr;
  logic [PTR_W-1:0] r_out_ptr;
  logic [CNT_W-1:0] w_alloc_cnt;
  logic [CNT_W-1:0] w_valid_cnt;
  logic [CNT_W-1:0] w_free_cnt;
  logic             w_flush;
  logic             w_retire;

  // Circular add on entry indices
  function automatic logic [PTR_W-1:0] ptr_add(logic [PTR_W-1:0] ptr, int unsigned n);
    int unsigned sum;
    sum = ptr + n;
    if (sum >= LDQ_SIZE) begin
      sum = sum - LDQ_SIZE;
    end
    return PTR_W'(sum);
  endfunction

  assign w_flush      = i_commit.valid & i_commit.flush;
  assign w_retire     = |i_retire;
  assign w_valid_cnt  = CNT_W'($countones(i_entry_valids));
  assign w_free_cnt   = CNT_W'(LDQ_SIZE) - w_valid_cnt;
  assign o_in_ptr_oh  = LDQ_SIZE'(1) << r_in_ptr;
  assign o_out_ptr_oh = LDQ_SIZE'(1) << r_out_ptr;

  // ------------------------------
  // Slot compaction
  // ------------------------------
  // Each valid slot lands at in_ptr plus its rank
  always_comb begin
    int unsigned      slot_rank;
    logic [PTR_W-1:0] slot_idx;
    slot_rank = 0;
    slot_idx  = '0;
    o_alloc   = '0;
    for (int e = 0; e < LDQ_SIZE; e++) begin
      o_alloc_cmt_id[e] = '0;
    end
    for (int s = 0; s < DISP_W; s++) begin
      if (i_disp[s].valid) begin
        slot_idx                 = ptr_add(r_in_ptr, slot_rank);
        o_alloc[slot_idx]        = 1'b1;
        o_alloc_cmt_id[slot_idx] = i_disp[s].cmt_id;
        slot_rank++;
      end
    end
    w_alloc_cnt = CNT_W'(slot_rank);
  end

  // ------------------------------
  // Pointers and credits
  // ------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_in_ptr       <= '0;
      r_out_ptr      <= '0;
      o_credit_valid <= 1'b0;
      o_credit_cnt   <= '0;
    end else begin
      o_credit_valid <= w_flush | w_retire;
      o_credit_cnt   <= w_flush ? w_valid_cnt : CNT_W'(w_retire);
      if (w_flush) begin
        r_in_ptr  <= '0;
        r_out_ptr <= '0;
      end else begin
        r_in_ptr <= ptr_add(r_in_ptr, w_alloc_cnt);
        if (w_retire) begin
          r_out_ptr <= ptr_add(r_out_ptr, 1);
        end
      end
    end
  end

  // Dispatch must stay within the credits it was given
  a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    w_alloc_cnt <= w_free_cnt);

endmodule

// File: src/ldq_entry.sv
// Load queue entry
`timescale 1ns/10ps

module ldq_entry #(
  parameter int LSU_PIPES = 2
) (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  logic                 i_alloc,
  input  ldq_pkg::cmt_id_t     i_alloc_cmt_id,
  input  ldq_pkg::ldq_upd_t    i_upd [LSU_PIPES],
  input  ldq_pkg::ldq_commit_t i_commit,
  input  logic                 i_at_out_ptr,
  output ldq_pkg::ldq_entry_t  o_entry,
  output logic                 o_retire
);
  import ldq_pkg::*;

  logic               r_valid;
  logic               r_updated;
  cmt_id_t            r_cmt_id;
  logic [PADDR_W-1:0] r_paddr;
  size_t              r_size;

  logic               w_upd_match;
  logic [PADDR_W-1:0] w_upd_paddr;
  size_t              w_upd_size;
  logic               w_flush;

  ldq_upd_select #(
    .LSU_PIPES (LSU_PIPES)
  ) u_upd_select (
    .i_upd    (i_upd),
    .i_valid  (r_valid),
    .i_cmt_id (r_cmt_id),
    .o_match  (w_upd_match),
    .o_paddr  (w_upd_paddr),
    .o_size   (w_upd_size)
  );

  assign w_flush = i_commit.valid & i_commit.flush;

  // Oldest entry, address known, commit names it
  assign o_retire = i_at_out_ptr & r_valid & r_updated &
                    i_commit.valid & ~i_commit.flush &
                    (i_commit.cmt_id == r_cmt_id);

  // ------------------------------
  // Entry state
  // ------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid   <= 1'b0;
      r_updated <= 1'b0;
    end else if (w_flush || o_retire) begin
      r_valid   <= 1'b0;
      r_updated <= 1'b0;
    end else if (i_alloc) begin
      r_valid   <= 1'b1;
      r_updated <= 1'b0;
    end else if (w_upd_match) begin
      r_updated <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_alloc) begin
      r_cmt_id <= i_alloc_cmt_id;
    end
    if (w_upd_match) begin
      r_paddr <= w_upd_paddr;
      r_size  <= w_upd_size;
    end
  end

  assign o_entry = '{valid: r_valid, updated: r_updated, cmt_id: r_cmt_id,
                     paddr: r_paddr, size: r_size};

  // Allocator must only pick free entries
  a_alloc_free: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_alloc |-> !r_valid);

endmodule

// File: src/ldq_haz_check.sv
// Store to load hazard check
`timescale 1ns/10ps

module ldq_haz_check #(
  parameter int LDQ_SIZE = 8
) (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  ldq_pkg::haz_req_t   i_haz_req,
  input  ldq_pkg::ldq_entry_t i_entries [LDQ_SIZE],
  input  logic [LDQ_SIZE-1:0] i_out_ptr_oh,
  output ldq_pkg::haz_rsp_t   o_haz_rsp
);
  import ldq_pkg::*;

  logic [7:0]          w_st_mask;
  logic [LDQ_SIZE-1:0] w_hit;
  logic [LDQ_SIZE-1:0] w_ge_mask;
  logic [LDQ_SIZE-1:0] w_hit_hi;
  logic [LDQ_SIZE-1:0] w_pick_src;
  logic [LDQ_SIZE-1:0] w_hit_oh;
  cmt_id_t             w_hit_cmt_id;

  logic                r_rsp_valid;
  cmt_id_t             r_rsp_cmt_id;

  assign w_st_mask = byte_mask(i_haz_req.size, i_haz_req.paddr[2:0]);

  // ------------------------------
  // Per entry match
  // ------------------------------
  always_comb begin
    for (int e = 0; e < LDQ_SIZE; e++) begin
      w_hit[e] = i_haz_req.valid &
                 i_entries[e].valid & i_entries[e].updated &
                 is_older(i_haz_req.cmt_id, i_entries[e].cmt_id) &
                 (i_entries[e].paddr[PADDR_W-1:3] == i_haz_req.paddr[PADDR_W-1:3]) &
                 (|(byte_mask(i_entries[e].size, i_entries[e].paddr[2:0]) & w_st_mask));
    end
  end

  // ------------------------------
  // Oldest pick
  // ------------------------------
  // Entries from out_ptr upward are older than the wrapped ones
  assign w_ge_mask  = ~(i_out_ptr_oh - 1'b1);
  assign w_hit_hi   = w_hit & w_ge_mask;
  assign w_pick_src = (|w_hit_hi) ? w_hit_hi : w_hit;
  assign w_hit_oh   = w_pick_src & (~w_pick_src + 1'b1);

  always_comb begin
    w_hit_cmt_id = '0;
    for (int e = 0; e < LDQ_SIZE; e++) begin
      w_hit_cmt_id = w_hit_cmt_id | ({CMT_ID_W{w_hit_oh[e]}} & i_entries[e].cmt_id);
    end
  end

  // ------------------------------
  // Registered response
  // ------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_rsp_valid <= 1'b0;
    end else begin
      r_rsp_valid <= |w_hit;
    end
  end

  always_ff @(posedge i_clk) begin
    r_rsp_cmt_id <= w_hit_cmt_id;
  end

  assign o_haz_rsp = '{valid: r_rsp_valid, cmt_id: r_rsp_cmt_id};

endmodule

// File: src/ldq_pkg.sv
// Load queue shared types
package ldq_pkg;

  // ------------------------------
  // Widths
  // ------------------------------
  localparam int PADDR_W  = 32;
  localparam int CMT_ID_W = 5;

  // MSB is the wrap bit, the rest indexes the ROB
  typedef logic [CMT_ID_W-1:0] cmt_id_t;

  // 0: 1 byte, 1: 2 bytes, 2: 4 bytes, 3: 8 bytes
  typedef logic [1:0] size_t;

  // ------------------------------
  // Payloads
  // ------------------------------
  typedef struct packed {
    logic    valid;
    cmt_id_t cmt_id;
  } ldq_disp_t;

  typedef struct packed {
    logic               valid;
    cmt_id_t            cmt_id;
    logic [PADDR_W-1:0] paddr;
    size_t              size;
  } ldq_upd_t;

  typedef struct packed {
    logic    valid;
    logic    flush;
    cmt_id_t cmt_id;
  } ldq_commit_t;

  typedef struct packed {
    logic               valid;
    cmt_id_t            cmt_id;
    logic [PADDR_W-1:0] paddr;
    size_t              size;
  } haz_req_t;

  typedef struct packed {
    logic    valid;
    cmt_id_t cmt_id;
  } haz_rsp_t;

  typedef struct packed {
    logic               valid;
    logic               updated;
    cmt_id_t            cmt_id;
    logic [PADDR_W-1:0] paddr;
    size_t              size;
  } ldq_entry_t;

  // ------------------------------
  // Helpers
  // ------------------------------
  // True when a is older than b
  function automatic logic is_older(cmt_id_t a, cmt_id_t b);
    logic same_wrap;
    same_wrap = (a[CMT_ID_W-1] == b[CMT_ID_W-1]);
    if (same_wrap) begin
      return a[CMT_ID_W-2:0] < b[CMT_ID_W-2:0];
    end
    return a[CMT_ID_W-2:0] > b[CMT_ID_W-2:0];
  endfunction

  // Bytes touched inside the doubleword
  function automatic logic [7:0] byte_mask(size_t size, logic [2:0] addr);
    logic [7:0] base;
    case (size)
      2'd0:    base = 8'h01;
      2'd1:    base = 8'h03;
      2'd2:    base = 8'h0f;
      default: base = 8'hff;
    endcase
    return base << addr;
  endfunction

endpackage

// File: src/ldq_top.sv
// Load queue top level
`timescale 1ns/10ps

module ldq_top #(
  parameter int LDQ_SIZE  = 8,
  parameter int DISP_W    = 2,
  parameter int LSU_PIPES = 2
) (
  input  logic                          i_clk,
  input  logic                          i_reset_n,
  input  ldq_pkg::ldq_disp_t            i_disp [DISP_W],
  input  ldq_pkg::ldq_upd_t             i_upd [LSU_PIPES],
  input  ldq_pkg::ldq_commit_t          i_commit,
  input  ldq_pkg::haz_req_t             i_haz_req [LSU_PIPES],
  output logic                          o_credit_valid,
  output logic [$clog2(LDQ_SIZE+1)-1:0] o_credit_cnt,
  output ldq_pkg::haz_rsp_t             o_haz_rsp [LSU_PIPES]
);
  import ldq_pkg::*;

  ldq_entry_t          w_entries [LDQ_SIZE];
  cmt_id_t             w_alloc_cmt_id [LDQ_SIZE];
  logic [LDQ_SIZE-1:0] w_entry_valids;
  logic [LDQ_SIZE-1:0] w_retire;
  logic [LDQ_SIZE-1:0] w_alloc;
  logic [LDQ_SIZE-1:0] w_in_ptr_oh;
  logic [LDQ_SIZE-1:0] w_out_ptr_oh;

  ldq_alloc #(
    .LDQ_SIZE (LDQ_SIZE),
    .DISP_W   (DISP_W)
  ) u_alloc (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_disp         (i_disp),
    .i_commit       (i_commit),
    .i_entry_valids (w_entry_valids),
    .i_retire       (w_retire),
    .o_alloc        (w_alloc),
    .o_alloc_cmt_id (w_alloc_cmt_id),
    .o_in_ptr_oh    (w_in_ptr_oh),
    .o_out_ptr_oh   (w_out_ptr_oh),
    .o_credit_valid (o_credit_valid),
    .o_credit_cnt   (o_credit_cnt)
  );

  // ------------------------------
  // Entries
  // ------------------------------
  for (genvar e = 0; e < LDQ_SIZE; e++) begin : g_entry
    ldq_entry #(
      .LSU_PIPES (LSU_PIPES)
    ) u_entry (
      .i_clk          (i_clk),
      .i_reset_n      (i_reset_n),
      .i_alloc        (w_alloc[e]),
      .i_alloc_cmt_id (w_alloc_cmt_id[e]),
      .i_upd          (i_upd),
      .i_commit       (i_commit),
      .i_at_out_ptr   (w_out_ptr_oh[e]),
      .o_entry        (w_entries[e]),
      .o_retire       (w_retire[e])
    );
    assign w_entry_valids[e] = w_entries[e].valid;
  end

  // One checker per store pipe
  for (genvar p = 0; p < LSU_PIPES; p++) begin : g_haz
    ldq_haz_check #(
      .LDQ_SIZE (LDQ_SIZE)
    ) u_haz_check (
      .i_clk        (i_clk),
      .i_reset_n    (i_reset_n),
      .i_haz_req    (i_haz_req[p]),
      .i_entries    (w_entries),
      .i_out_ptr_oh (w_out_ptr_oh),
      .o_haz_rsp    (o_haz_rsp[p])
    );
  end

  // Empty queue means the pointers have met
  a_empty_ptrs: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (w_entry_valids == '0) |-> (w_in_ptr_oh == w_out_ptr_oh));

endmodule

// File: src/ldq_upd_select.sv
// EX2 update match for one entry
`timescale 1ns/10ps

module ldq_upd_select #(
  parameter int LSU_PIPES = 2
) (
  input  ldq_pkg::ldq_upd_t           i_upd [LSU_PIPES],
  input  logic                        i_valid,
  input  ldq_pkg::cmt_id_t            i_cmt_id,
  output logic                        o_match,
  output logic [ldq_pkg::PADDR_W-1:0] o_paddr,
  output ldq_pkg::size_t              o_size
);
  import ldq_pkg::*;

  logic [LSU_PIPES-1:0] w_hit;

  always_comb begin
    for (int p = 0; p < LSU_PIPES; p++) begin
      w_hit[p] = i_valid & i_upd[p].valid & (i_upd[p].cmt_id == i_cmt_id);
    end
  end

  assign o_match = |w_hit;

  // AND-OR select of the hitting pipe
  always_comb begin
    o_paddr = '0;
    o_size  = '0;
    for (int p = 0; p < LSU_PIPES; p++) begin
      o_paddr = o_paddr | ({PADDR_W{w_hit[p]}} & i_upd[p].paddr);
      o_size  = o_size | ({$bits(size_t){w_hit[p]}} & i_upd[p].size);
    end
  end

  // A load runs down one pipe at a time
  always_comb begin
    a_one_pipe: assert final ($onehot0(w_hit));
  end

endmodule

// File: test/ldq_tb.sv
// Load queue testbench
`timescale 1ns/10ps

module ldq_tb;
  import ldq_pkg::*;

  localparam int LDQ_SIZE    = 8;
  localparam int DISP_W      = 2;
  localparam int LSU_PIPES   = 2;
  localparam int CNT_W       = $clog2(LDQ_SIZE+1);
  localparam int HAZ_CYCLES  = 60;
  localparam int WRAP_CYCLES = 400;
  // Sum of test lengths plus five drains of at most ten cycles per entry and a margin
  localparam int MAX_CYCLES  = 30 + 4 * LDQ_SIZE + HAZ_CYCLES + WRAP_CYCLES +
                               50 * LDQ_SIZE + 200;

  typedef struct packed {
    cmt_id_t            id;
    logic [PADDR_W-1:0] paddr;
    size_t              size;
    logic               upd;
  } load_t;

  typedef struct packed {
    logic             valid;
    logic [CNT_W-1:0] cnt;
  } credit_t;

  logic             i_clk;
  logic             i_reset_n;
  ldq_disp_t        i_disp [DISP_W];
  ldq_upd_t         i_upd [LSU_PIPES];
  ldq_commit_t      i_commit;
  haz_req_t         i_haz_req [LSU_PIPES];
  logic             o_credit_valid;
  logic [CNT_W-1:0] o_credit_cnt;
  haz_rsp_t         o_haz_rsp [LSU_PIPES];

  // Outstanding loads, oldest at the front
  load_t       mq [$];
  haz_rsp_t    exp_haz_next [LSU_PIPES];
  haz_rsp_t    exp_haz [LSU_PIPES];
  credit_t     exp_credit_next;
  credit_t     exp_credit;
  logic [31:0] lfsr;
  cmt_id_t     next_id;
  string       cur_test;
  int          test_errs;
  int          total_errs;
  int          tests_run;
  int          tests_failed;
  int          credit_sum;
  int          hit_count;
  int          rsp_hits;
  int          cycles;

  ldq_top #(
    .LDQ_SIZE  (LDQ_SIZE),
    .DISP_W    (DISP_W),
    .LSU_PIPES (LSU_PIPES)
  ) dut_i (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_disp         (i_disp),
    .i_upd          (i_upd),
    .i_commit       (i_commit),
    .i_haz_req      (i_haz_req),
    .o_credit_valid (o_credit_valid),
    .o_credit_cnt   (o_credit_cnt),
    .o_haz_rsp      (o_haz_rsp)
  );

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  // ------------------------------
  // Reference model
  // ------------------------------
  // Fibonacci LFSR, taps 32 22 2 1
  function automatic int rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v    = {v[30:0], lfsr[0]};
    end
    return int'(v);
  endfunction

  // Four doublewords, so loads and stores collide often
  function automatic logic [PADDR_W-1:0] rand_addr(size_t sz);
    int dw;
    int off;
    dw  = rand_bits(2);
    off = rand_bits(3) & ~((1 << sz) - 1);
    return 32'h4000_0000 | PADDR_W'(dw * 8 + off);
  endfunction

  // Load lies 1 to 15 IDs after the store
  function automatic bit younger(cmt_id_t st, cmt_id_t ld);
    cmt_id_t d;
    d = ld - st;
    return !d[CMT_ID_W-1] && (d != '0);
  endfunction

  function automatic logic [7:0] touched(size_t sz, logic [2:0] off);
    logic [7:0] m;
    int         o;
    int         nbytes;
    o      = int'(off);
    nbytes = 1 << sz;
    for (int b = 0; b < 8; b++) begin
      m[b] = (b >= o) && (b < o + nbytes);
    end
    return m;
  endfunction

  // Oldest updated, younger, overlapping load wins
  function automatic haz_rsp_t ref_haz(haz_req_t r);
    haz_rsp_t rsp;
    rsp = '0;
    foreach (mq[i]) begin
      if (!rsp.valid && mq[i].upd && younger(r.cmt_id, mq[i].id) &&
          (mq[i].paddr[PADDR_W-1:3] == r.paddr[PADDR_W-1:3]) &&
          (|(touched(mq[i].size, mq[i].paddr[2:0]) & touched(r.size, r.paddr[2:0])))) begin
        rsp = '{valid: 1'b1, cmt_id: mq[i].id};
      end
    end
    return rsp;
  endfunction

  // ------------------------------
  // Stimulus
  // ------------------------------
  task automatic idle_inputs();
    for (int s = 0; s < DISP_W; s++) begin
      i_disp[s] = '0;
    end
    for (int p = 0; p < LSU_PIPES; p++) begin
      i_upd[p]        = '0;
      i_haz_req[p]    = '0;
      exp_haz_next[p] = '0;
    end
    i_commit        = '0;
    exp_credit_next = '0;
  endtask

  task automatic next_cycle();
    @(posedge i_clk);
    #1;
    idle_inputs();
  endtask

  task automatic send_loads(int n);
    load_t ld;
    for (int s = 0; s < n; s++) begin
      ld.id     = next_id;
      ld.size   = size_t'(rand_bits(2));
      ld.paddr  = rand_addr(ld.size);
      ld.upd    = 1'b0;
      i_disp[s] = '{valid: 1'b1, cmt_id: next_id};
      mq.push_back(ld);
      next_id++;
    end
  endtask

  task automatic send_update(int p, int idx);
    i_upd[p] = '{valid: 1'b1, cmt_id: mq[idx].id, paddr: mq[idx].paddr, size: mq[idx].size};
    mq[idx].upd = 1'b1;
  endtask

  task automatic send_commit(bit flush);
    if (flush) begin
      i_commit        = '{valid: 1'b1, flush: 1'b1, cmt_id: '0};
      exp_credit_next = '{valid: 1'b1, cnt: CNT_W'(mq.size())};
      mq.delete();
    end else begin
      i_commit        = '{valid: 1'b1, flush: 1'b0, cmt_id: mq[0].id};
      exp_credit_next = '{valid: 1'b1, cnt: CNT_W'(1)};
      void'(mq.pop_front());
    end
  endtask

  // Expected response comes from the queue as it stands before this edge
  task automatic send_store(int p, cmt_id_t id, logic [PADDR_W-1:0] paddr, size_t sz);
    haz_req_t r;
    r               = '{valid: 1'b1, cmt_id: id, paddr: paddr, size: sz};
    i_haz_req[p]    = r;
    exp_haz_next[p] = ref_haz(r);
    if (exp_haz_next[p].valid) begin
      hit_count++;
    end
  endtask

  task automatic random_store(int p);
    cmt_id_t base;
    size_t   sz;
    base = (mq.size() > 0) ? mq[0].id : next_id;
    sz   = size_t'(rand_bits(2));
    send_store(p, cmt_id_t'(base - 1 + rand_bits(4) % (mq.size() + 1)), rand_addr(sz), sz);
  endtask

  // Order inside a cycle: stores, commit, updates, then dispatch
  task automatic mixed_cycle(bit disp_en, bit cmt_en, bit haz_en);
    int room;
    int n;
    int idx;
    int start;
    int j;
    next_cycle();
    room = LDQ_SIZE - mq.size();
    for (int p = 0; p < LSU_PIPES; p++) begin
      if (haz_en && rand_bits(1) == 1) begin
        random_store(p);
      end
    end
    if (cmt_en && mq.size() > 0 && mq[0].upd && rand_bits(1) == 1) begin
      send_commit(1'b0);
    end
    for (int p = 0; p < LSU_PIPES; p++) begin
      idx   = -1;
      start = rand_bits(3);
      for (int k = 0; k < mq.size(); k++) begin
        j = (start + k) % mq.size();
        if (idx < 0 && !mq[j].upd) begin
          idx = j;
        end
      end
      if (idx >= 0 && rand_bits(1) == 1) begin
        send_update(p, idx);
      end
    end
    n = disp_en ? rand_bits(2) % (DISP_W + 1) : 0;
    if (n > room) begin
      n = room;
    end
    send_loads(n);
  endtask

  task automatic drain();
    while (mq.size() > 0) begin
      mixed_cycle(1'b0, 1'b1, 1'b0);
    end
    next_cycle();
    next_cycle();
  endtask

  task automatic note_error();
    test_errs++;
    total_errs++;
  endtask

  task automatic start_test(string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errs == 0) begin
      $display("PASS  %s", cur_test);
    end else begin
      tests_failed++;
      $display("FAIL  %s (%0d errors)", cur_test, test_errs);
    end
  endtask

  // ------------------------------
  // Checking
  // ------------------------------
  always @(posedge i_clk) begin
    exp_credit = exp_credit_next;
    for (int p = 0; p < LSU_PIPES; p++) begin
      exp_haz[p] = exp_haz_next[p];
    end
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("Timeout: run went past %0d cycles", MAX_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  // Outputs are settled at the falling edge
  always @(negedge i_clk) begin
    if (o_credit_valid) begin
      credit_sum += int'(o_credit_cnt);
    end
    if (o_credit_valid !== exp_credit.valid ||
        (exp_credit.valid && o_credit_cnt !== exp_credit.cnt)) begin
      $display("** Error: %s credit expected %0b/%0d actual %0b/%0d", cur_test,
               exp_credit.valid, exp_credit.cnt, o_credit_valid, o_credit_cnt);
      note_error();
    end
    for (int p = 0; p < LSU_PIPES; p++) begin
      if (o_haz_rsp[p].valid) begin
        rsp_hits++;
      end
      if (o_haz_rsp[p].valid !== exp_haz[p].valid ||
          (exp_haz[p].valid && o_haz_rsp[p].cmt_id !== exp_haz[p].cmt_id)) begin
        $display("** Error: %s hazard pipe %0d expected %0b/%h actual %0b/%h", cur_test, p,
                 exp_haz[p].valid, exp_haz[p].cmt_id, o_haz_rsp[p].valid, o_haz_rsp[p].cmt_id);
        note_error();
      end
    end
  end

  initial begin
    lfsr         = 32'h933e0e66;
    next_id      = '0;
    total_errs   = 0;
    tests_run    = 0;
    tests_failed = 0;
    credit_sum   = 0;
    hit_count    = 0;
    rsp_hits     = 0;
    cycles       = 0;
    exp_credit   = '0;
    for (int p = 0; p < LSU_PIPES; p++) begin
      exp_haz[p] = '0;
    end
    i_reset_n = 1'b0;
    idle_inputs();
    start_test("reset_idle");
    repeat (10) @(posedge i_clk);
    #1;
    i_reset_n = 1'b1;
    repeat (20) next_cycle();
    end_test();

    start_test("fill_retire");
    credit_sum = 0;
    while (mq.size() < LDQ_SIZE) begin
      next_cycle();
      send_loads((LDQ_SIZE - mq.size() > 1) ? 1 + rand_bits(1) : 1);
    end
    drain();
    if (credit_sum != LDQ_SIZE) begin
      $display("** Error: %s credit total expected %0d actual %0d", cur_test,
               LDQ_SIZE, credit_sum);
      note_error();
    end
    end_test();

    start_test("store_hazard");
    repeat (4 * LDQ_SIZE) mixed_cycle(1'b1, 1'b0, 1'b0);
    hit_count = 0;
    repeat (HAZ_CYCLES) mixed_cycle(1'b0, 1'b0, 1'b1);
    if (hit_count == 0) begin
      $display("%s: no store request ever overlapped a load", cur_test);
      note_error();
    end
    drain();
    end_test();

    // Load 0 holds bytes 0..3 and is updated, load 1 shares them but is not
    start_test("non_hazard");
    next_cycle();
    send_loads(2);
    mq[0].paddr = 32'h4000_0010;
    mq[0].size  = 2'd2;
    mq[1].paddr = 32'h4000_0010;
    mq[1].size  = 2'd2;
    next_cycle();
    send_update(0, 0);
    rsp_hits = 0;
    next_cycle();
    send_store(0, mq[1].id, 32'h4000_0010, 2'd3);
    send_store(1, cmt_id_t'(mq[0].id - 1), 32'h4000_0018, 2'd3);
    next_cycle();
    send_store(0, cmt_id_t'(mq[0].id - 1), 32'h4000_0014, 2'd2);
    send_store(1, mq[0].id, 32'h4000_0010, 2'd3);
    next_cycle();
    send_store(0, cmt_id_t'(mq[0].id - 1), 32'h4000_0012, 2'd0);
    drain();
    // Only the last store overlaps an updated younger load
    if (rsp_hits != 1) begin
      $display("** Error: %s hit responses expected 1 actual %0d", cur_test, rsp_hits);
      note_error();
    end
    end_test();

    start_test("flush");
    repeat (1 + rand_bits(3)) mixed_cycle(1'b1, 1'b0, 1'b0);
    next_cycle();
    send_commit(1'b1);
    while (mq.size() < LDQ_SIZE) begin
      next_cycle();
      send_loads((LDQ_SIZE - mq.size() < DISP_W) ? LDQ_SIZE - mq.size() : DISP_W);
    end
    drain();
    end_test();

    start_test("wrap_around");
    repeat (WRAP_CYCLES) mixed_cycle(1'b1, 1'b1, 1'b1);
    drain();
    end_test();

    $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, total_errs);
    if (total_errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
